//--- sources.f
src/boot_cfg_pkg.sv
src/boot_types_pkg.sv
src/mem_req_if.sv
src/image_intake.sv
src/word_fifo.sv
src/image_writer.sv
src/boot_sequencer.sv
src/boot_top.sv
tests/dram_model.sv
tests/boot_tb.sv

//--- Bender.yml
package:
  name: mem_boot_sequencer

sources:
  - files:
      - src/boot_cfg_pkg.sv
      - src/boot_types_pkg.sv
      - src/mem_req_if.sv
      - src/image_intake.sv
      - src/word_fifo.sv
      - src/image_writer.sv
      - src/boot_sequencer.sv
      - src/boot_top.sv
  - target: test
    files:
      - tests/dram_model.sv
      - tests/boot_tb.sv

//--- tests/boot_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory boot sequencer testbench
// two boot runs (clean and with one corrupted word) plus host access
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module boot_tb;
    import boot_cfg_pkg::*;

    localparam int HOST_OPS       = 4;
    localparam int HOST_ACCESSES  = 2 * HOST_OPS;  // writes and reads
    localparam int TIMEOUT_CYCLES = 20 * (MEM_WORDS + 2 * IMAGE_WORDS + HOST_ACCESSES);
    localparam int CORRUPT_ADDR   = 7;

    logic              clk;
    logic              i_rst_n;
    logic              i_src_valid;
    logic [DATA_W-1:0] i_src_data;
    logic              o_src_ready;
    logic              mem_rd_en;
    logic              mem_wr_en;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic [DATA_W-1:0] mem_rdata;
    logic              mem_rvalid;
    logic              mem_busy;
    logic              i_host_rd_en;
    logic              i_host_wr_en;
    logic [DATA_W-1:0] i_host_addr;
    logic [DATA_W-1:0] i_host_wdata;
    logic [DATA_W-1:0] o_host_rdata;
    logic              o_host_rvalid;
    logic              o_host_busy;
    logic              o_init_done;
    logic              o_checksum_ok;
    logic [DATA_W-1:0] o_load_checksum;
    logic              corrupt_en;

    integer            seed;
    int                err_cnt;
    int                check_cnt;
    int                cycle_cnt;
    int                taken_cnt;
    logic              stall_seen;
    logic [DATA_W-1:0] image_words [IMAGE_WORDS];
    logic [DATA_W-1:0] host_addrs  [HOST_OPS];
    logic [DATA_W-1:0] host_data   [HOST_OPS];

    boot_top #(
        .MEM_WORDS   (MEM_WORDS),
        .IMAGE_WORDS (IMAGE_WORDS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) boot_top_inst (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_src_valid     (i_src_valid),
        .i_src_data      (i_src_data),
        .o_src_ready     (o_src_ready),
        .o_mem_rd_en     (mem_rd_en),
        .o_mem_wr_en     (mem_wr_en),
        .o_mem_addr      (mem_addr),
        .o_mem_wdata     (mem_wdata),
        .i_mem_rdata     (mem_rdata),
        .i_mem_rvalid    (mem_rvalid),
        .i_mem_busy      (mem_busy),
        .i_host_rd_en    (i_host_rd_en),
        .i_host_wr_en    (i_host_wr_en),
        .i_host_addr     (i_host_addr),
        .i_host_wdata    (i_host_wdata),
        .o_host_rdata    (o_host_rdata),
        .o_host_rvalid   (o_host_rvalid),
        .o_host_busy     (o_host_busy),
        .o_init_done     (o_init_done),
        .o_checksum_ok   (o_checksum_ok),
        .o_load_checksum (o_load_checksum)
    );

    dram_model #(
        .MEM_WORDS (MEM_WORDS),
        .SEED      (32'hef326525)
    ) dram_model_inst (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_rd_en        (mem_rd_en),
        .i_wr_en        (mem_wr_en),
        .i_addr         (mem_addr),
        .i_wdata        (mem_wdata),
        .o_rdata        (mem_rdata),
        .o_rvalid       (mem_rvalid),
        .o_busy         (mem_busy),
        .i_corrupt_en   (corrupt_en),
        .i_corrupt_addr (ADDR_W'(CORRUPT_ADDR))
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // wrapped sum of the image words, as the load phase should compute it
    function automatic logic [DATA_W-1:0] expected_checksum();
        logic [DATA_W-1:0] sum;
        sum = '0;
        for (int i = 0; i < IMAGE_WORDS; i++)
            sum = sum + image_words[i];
        return sum;
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic apply_reset();
        i_rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        check_value("o_init_done in reset", o_init_done, 1'b0);
        check_value("o_checksum_ok in reset", o_checksum_ok, 1'b0);
        check_value("o_mem_rd_en in reset", mem_rd_en, 1'b0);
        check_value("o_mem_wr_en in reset", mem_wr_en, 1'b0);
        check_value("o_host_busy in reset", o_host_busy, 1'b1);
        i_rst_n = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("o_src_ready after reset", o_src_ready, 1'b1);
        @(posedge clk);
        #1;
    endtask

    // present one word and hold it until the intake takes it
    task automatic send_word(input logic [DATA_W-1:0] data);
        i_src_valid = 1'b1;
        i_src_data  = data;
        @(negedge clk);
        while (!o_src_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
        i_src_valid = 1'b0;
    endtask

    task automatic boot_once();
        taken_cnt  = 0;
        stall_seen = 1'b0;
        apply_reset();
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            repeat ($unsigned($random(seed)) % 3) begin    // idle gap on the source
                @(posedge clk);
                #1;
            end
            send_word(image_words[i]);
        end
        // one word past the image stays on offer, the intake must refuse it
        i_src_valid = 1'b1;
        i_src_data  = $random(seed);
        while (!o_init_done)
            @(negedge clk);
        @(posedge clk);
        #1;
        i_src_valid = 1'b0;
    endtask

    task automatic host_write(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data);
        i_host_wr_en = 1'b1;
        i_host_addr  = addr;
        i_host_wdata = data;
        @(negedge clk);
        while (o_host_busy)
            @(negedge clk);
        @(posedge clk);     // granted on this edge
        #1;
        i_host_wr_en = 1'b0;
    endtask

    task automatic host_read(input logic [DATA_W-1:0] addr, output logic [DATA_W-1:0] data);
        i_host_rd_en = 1'b1;
        i_host_addr  = addr;
        @(negedge clk);
        while (o_host_busy)
            @(negedge clk);
        @(posedge clk);
        #1;
        i_host_rd_en = 1'b0;
        do
            @(negedge clk);
        while (!o_host_rvalid);
        data = o_host_rdata;
        @(posedge clk);
        #1;
    endtask

    // boot-time port rules and source take counting
    always @(negedge clk) begin
        if (i_rst_n && !o_init_done) begin
            check_value("o_host_busy during boot", o_host_busy, 1'b1);
            check_value("o_host_rvalid during boot", o_host_rvalid, 1'b0);
            if (mem_rd_en || mem_wr_en)
                check_value("o_mem_addr inside region", mem_addr < MEM_WORDS, 1'b1);
        end
        if (i_rst_n && i_src_valid && o_src_ready)
            taken_cnt++;
        if (i_rst_n && taken_cnt > 0 && taken_cnt < IMAGE_WORDS && !o_src_ready)
            stall_seen = 1'b1;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("checks: %0d, errors: %0d, timeouts: 1", check_cnt, err_cnt);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [DATA_W-1:0] rd_data;

        i_rst_n      = 1'b0;
        i_src_valid  = 1'b0;
        i_src_data   = '0;
        i_host_rd_en = 1'b0;
        i_host_wr_en = 1'b0;
        i_host_addr  = '0;
        i_host_wdata = '0;
        corrupt_en   = 1'b0;
        err_cnt      = 0;
        check_cnt    = 0;
        seed         = 32'hef326525;
        for (int i = 0; i < IMAGE_WORDS; i++)
            image_words[i] = $random(seed);

        // clean boot
        boot_once();
        check_value("source words taken", taken_cnt, IMAGE_WORDS);
        check_value("o_src_ready stall seen", stall_seen, 1'b1);
        check_value("o_load_checksum", o_load_checksum, expected_checksum());
        check_value("o_checksum_ok", o_checksum_ok, 1'b1);
        for (int a = 0; a < MEM_WORDS; a++) begin
            if (a < IMAGE_WORDS) begin
                check_value($sformatf("mem[%0d]", a), dram_model_inst.mem[a], image_words[a]);
                check_value($sformatf("writes to %0d", a), dram_model_inst.wr_cnt[a], 2);
            end else begin
                check_value($sformatf("mem[%0d]", a), dram_model_inst.mem[a], '0);
                check_value($sformatf("writes to %0d", a), dram_model_inst.wr_cnt[a], 1);
            end
        end

        // host owns the port, upper address bits must be dropped
        @(posedge clk);
        #1;
        for (int i = 0; i < HOST_OPS; i++) begin
            host_addrs[i] = {20'($random(seed)), 12'((i * 13 + 3) % MEM_WORDS)};
            host_data[i]  = $random(seed);
            host_write(host_addrs[i], host_data[i]);
        end
        for (int i = 0; i < HOST_OPS; i++) begin
            host_read(host_addrs[i], rd_data);
            check_value($sformatf("o_host_rdata[%0d]", i), rd_data, host_data[i]);
        end

        // second boot with one image word corrupted in memory
        corrupt_en = 1'b1;
        boot_once();
        check_value("source words taken, run 2", taken_cnt, IMAGE_WORDS);
        check_value("o_load_checksum, run 2", o_load_checksum, expected_checksum());
        check_value("o_checksum_ok, run 2", o_checksum_ok, 1'b0);

        $display("checks: %0d, errors: %0d, timeouts: 0", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/dram_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral DRAM model for the boot testbench
// busy/idle request port, random busy time, per-address write counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module dram_model #(
    parameter int          MEM_WORDS = boot_cfg_pkg::MEM_WORDS,
    parameter logic [31:0] SEED      = 32'hef326525
) (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_rd_en,
    input  logic                            i_wr_en,
    input  logic [boot_cfg_pkg::ADDR_W-1:0] i_addr,
    input  logic [boot_cfg_pkg::DATA_W-1:0] i_wdata,
    output logic [boot_cfg_pkg::DATA_W-1:0] o_rdata,
    output logic                            o_rvalid,
    output logic                            o_busy,
    input  logic                            i_corrupt_en,
    input  logic [boot_cfg_pkg::ADDR_W-1:0] i_corrupt_addr
);
    import boot_cfg_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    int unsigned       wr_cnt [MEM_WORDS];
    integer            seed;
    logic [2:0]        busy_cnt;
    logic              rd_pending;
    logic [ADDR_W-1:0] rd_addr;
    logic              accept;

    assign accept = (i_rd_en || i_wr_en) && !o_busy;

    initial begin
        seed = SEED;
        for (int a = 0; a < MEM_WORDS; a++)
            mem[a] = 32'hc0de0000 ^ (a * 32'h00010001);    // stale content before boot
    end

    always @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_busy     <= 1'b0;
            o_rvalid   <= 1'b0;
            busy_cnt   <= '0;
            rd_pending <= 1'b0;
            for (int a = 0; a < MEM_WORDS; a++)
                wr_cnt[a] <= 0;
        end else begin
            o_rvalid <= 1'b0;
            if (accept) begin
                o_busy     <= 1'b1;
                busy_cnt   <= 3'd1 + 3'($unsigned($random(seed)) % 4);  // 1 to 4 cycles
                rd_pending <= i_rd_en;
                rd_addr    <= i_addr;
                if (i_wr_en && i_addr < MEM_WORDS) begin
                    wr_cnt[i_addr] <= wr_cnt[i_addr] + 1;
                    // second write is the image word, after zero fill
                    if (i_corrupt_en && i_addr == i_corrupt_addr && wr_cnt[i_addr] == 1)
                        mem[i_addr] <= i_wdata ^ 32'h0000_0100;
                    else
                        mem[i_addr] <= i_wdata;
                end
            end else if (o_busy) begin
                if (busy_cnt == 3'd1) begin
                    o_busy <= 1'b0;
                    if (rd_pending) begin
                        o_rvalid <= 1'b1;
                        o_rdata  <= (rd_addr < MEM_WORDS) ? mem[rd_addr] : '0;
                    end
                end else begin
                    busy_cnt <= busy_cnt - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/boot_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory boot top level
// source intake, word buffer, image writer and boot sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module boot_top #(
    parameter int MEM_WORDS   = boot_cfg_pkg::MEM_WORDS,
    parameter int IMAGE_WORDS = boot_cfg_pkg::IMAGE_WORDS,
    parameter int FIFO_DEPTH  = boot_cfg_pkg::FIFO_DEPTH
) (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_src_valid,
    input  logic [boot_cfg_pkg::DATA_W-1:0] i_src_data,
    output logic                            o_src_ready,
    output logic                            o_mem_rd_en,
    output logic                            o_mem_wr_en,
    output logic [boot_cfg_pkg::ADDR_W-1:0] o_mem_addr,
    output logic [boot_cfg_pkg::DATA_W-1:0] o_mem_wdata,
    input  logic [boot_cfg_pkg::DATA_W-1:0] i_mem_rdata,
    input  logic                            i_mem_rvalid,
    input  logic                            i_mem_busy,
    input  logic                            i_host_rd_en,
    input  logic                            i_host_wr_en,
    input  logic [boot_cfg_pkg::DATA_W-1:0] i_host_addr,
    input  logic [boot_cfg_pkg::DATA_W-1:0] i_host_wdata,
    output logic [boot_cfg_pkg::DATA_W-1:0] o_host_rdata,
    output logic                            o_host_rvalid,
    output logic                            o_host_busy,
    output logic                            o_init_done,
    output logic                            o_checksum_ok,
    output logic [boot_cfg_pkg::DATA_W-1:0] o_load_checksum
);
    import boot_cfg_pkg::*;

    logic              a_valid;     // intake to buffer
    logic [DATA_W-1:0] a_word;
    logic              a_credit;
    logic              b_valid;     // buffer to writer
    logic [DATA_W-1:0] b_word;
    logic              b_credit;
    logic              load_complete;

    mem_req_if wr_req ();

    image_intake #(
        .IMAGE_WORDS (IMAGE_WORDS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) image_intake_inst (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_src_valid     (i_src_valid),
        .i_src_data      (i_src_data),
        .o_src_ready     (o_src_ready),
        .o_word_valid    (a_valid),
        .o_word          (a_word),
        .i_credit_ret    (a_credit),
        .o_checksum      (o_load_checksum),
        .o_load_complete (load_complete)
    );

    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) word_fifo_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_in_valid   (a_valid),
        .i_in_word    (a_word),
        .o_credit_ret (a_credit),
        .o_out_valid  (b_valid),
        .o_out_word   (b_word),
        .i_out_credit (b_credit)
    );

    image_writer image_writer_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_word_valid (b_valid),
        .i_word       (b_word),
        .o_credit_ret (b_credit),
        .req          (wr_req.master)
    );

    boot_sequencer #(
        .MEM_WORDS   (MEM_WORDS),
        .IMAGE_WORDS (IMAGE_WORDS)
    ) boot_sequencer_inst (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .wr_req          (wr_req.slave),
        .i_load_complete (load_complete),
        .i_load_checksum (o_load_checksum),
        .o_mem_rd_en     (o_mem_rd_en),
        .o_mem_wr_en     (o_mem_wr_en),
        .o_mem_addr      (o_mem_addr),
        .o_mem_wdata     (o_mem_wdata),
        .i_mem_rdata     (i_mem_rdata),
        .i_mem_rvalid    (i_mem_rvalid),
        .i_mem_busy      (i_mem_busy),
        .i_host_rd_en    (i_host_rd_en),
        .i_host_wr_en    (i_host_wr_en),
        .i_host_addr     (i_host_addr),
        .i_host_wdata    (i_host_wdata),
        .o_host_rdata    (o_host_rdata),
        .o_host_rvalid   (o_host_rvalid),
        .o_host_busy     (o_host_busy),
        .o_init_done     (o_init_done),
        .o_checksum_ok   (o_checksum_ok)
    );

endmodule

`default_nettype wire

//--- src/boot_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot sequencer
// zero fill, load forwarding, verify readback, then host pass-through
// owns the single registered memory request port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module boot_sequencer #(
    parameter int MEM_WORDS   = boot_cfg_pkg::MEM_WORDS,
    parameter int IMAGE_WORDS = boot_cfg_pkg::IMAGE_WORDS
) (
    input  logic                            clk,
    input  logic                            i_rst_n,
    mem_req_if.slave                        wr_req,
    input  logic                            i_load_complete,
    input  logic [boot_cfg_pkg::DATA_W-1:0] i_load_checksum,
    output logic                            o_mem_rd_en,
    output logic                            o_mem_wr_en,
    output logic [boot_cfg_pkg::ADDR_W-1:0] o_mem_addr,
    output logic [boot_cfg_pkg::DATA_W-1:0] o_mem_wdata,
    input  logic [boot_cfg_pkg::DATA_W-1:0] i_mem_rdata,
    input  logic                            i_mem_rvalid,
    input  logic                            i_mem_busy,
    input  logic                            i_host_rd_en,
    input  logic                            i_host_wr_en,
    input  logic [boot_cfg_pkg::DATA_W-1:0] i_host_addr,
    input  logic [boot_cfg_pkg::DATA_W-1:0] i_host_wdata,
    output logic [boot_cfg_pkg::DATA_W-1:0] o_host_rdata,
    output logic                            o_host_rvalid,
    output logic                            o_host_busy,
    output logic                            o_init_done,
    output logic                            o_checksum_ok
);
    import boot_cfg_pkg::*;
    import boot_types_pkg::*;

    boot_phase_t       phase;
    logic [ADDR_W:0]   seq_cnt;     // fill address, load count or verify address
    logic [DATA_W-1:0] verify_sum;
    logic              rd_wait;     // verify read out, data not back yet
    logic              port_busy;
    logic              grant;
    mem_op_t           req_op;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;

    // output stage still holding a request, or memory still working
    assign port_busy = o_mem_rd_en || o_mem_wr_en || i_mem_busy;
    assign grant     = (req_op != IDLE) && !port_busy;

    assign wr_req.busy   = (phase != LOAD) || port_busy;
    assign wr_req.rdata  = i_mem_rdata;
    assign wr_req.rvalid = (phase == LOAD) && i_mem_rvalid;

    assign o_init_done   = (phase == RUN);
    assign o_host_busy   = (phase != RUN) || port_busy;
    assign o_host_rdata  = i_mem_rdata;
    assign o_host_rvalid = (phase == RUN) && i_mem_rvalid;

    // request source for the current phase
    always_comb begin
        req_op    = IDLE;
        req_addr  = seq_cnt[ADDR_W-1:0];
        req_wdata = '0;
        case (phase)
            ZERO: if (seq_cnt < MEM_WORDS) req_op = WRITE;
            LOAD: begin
                req_op    = wr_req.op;
                req_addr  = wr_req.addr;
                req_wdata = wr_req.wdata;
            end
            VERIFY: if (seq_cnt < IMAGE_WORDS && !rd_wait) req_op = READ;
            RUN: begin
                if (i_host_wr_en)
                    req_op = WRITE;
                else if (i_host_rd_en)
                    req_op = READ;
                req_addr  = i_host_addr[ADDR_W-1:0];   // upper bits dropped
                req_wdata = i_host_wdata;
            end
            default: req_op = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase         <= ZERO;
            seq_cnt       <= '0;
            verify_sum    <= '0;
            rd_wait       <= 1'b0;
            o_checksum_ok <= 1'b0;
            o_mem_rd_en   <= 1'b0;
            o_mem_wr_en   <= 1'b0;
        end else begin
            if (grant) begin
                o_mem_rd_en <= (req_op == READ);
                o_mem_wr_en <= (req_op == WRITE);
            end else if (!i_mem_busy) begin
                o_mem_rd_en <= 1'b0;    // taken by the memory
                o_mem_wr_en <= 1'b0;
            end

            if (grant && phase != RUN)
                seq_cnt <= seq_cnt + 1'b1;

            case (phase)
                ZERO: begin
                    if (seq_cnt == MEM_WORDS && !port_busy) begin
                        phase   <= LOAD;
                        seq_cnt <= '0;
                    end
                end
                LOAD: begin
                    // intake done and the last write has left the port
                    if (i_load_complete && seq_cnt == IMAGE_WORDS && !port_busy) begin
                        phase   <= VERIFY;
                        seq_cnt <= '0;
                    end
                end
                VERIFY: begin
                    if (grant)
                        rd_wait <= 1'b1;
                    if (rd_wait && i_mem_rvalid) begin
                        verify_sum <= verify_sum + i_mem_rdata;
                        rd_wait    <= 1'b0;
                    end
                    if (seq_cnt == IMAGE_WORDS && !rd_wait && !port_busy) begin
                        phase         <= RUN;
                        o_checksum_ok <= (verify_sum == i_load_checksum);
                    end
                end
                default: phase <= RUN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            o_mem_addr  <= req_addr;
            o_mem_wdata <= req_wdata;
        end
    end

endmodule

`default_nettype wire

//--- src/image_writer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// image writer
// turns buffered words into sequential memory writes from address 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module image_writer (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_word_valid,
    input  logic [boot_cfg_pkg::DATA_W-1:0] i_word,
    output logic                            o_credit_ret,
    mem_req_if.master                       req
);
    import boot_cfg_pkg::*;
    import boot_types_pkg::*;

    typedef enum logic [1:0] {
        W_EMPTY,    // holding register free
        W_REQ,      // write presented, waiting for acceptance
        W_WAIT      // accepted, waiting for busy to clear
    } wr_state_t;

    wr_state_t         state;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] hold_word;

    assign req.op    = (state == W_REQ) ? WRITE : IDLE;
    assign req.addr  = wr_addr;
    assign req.wdata = hold_word;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= W_EMPTY;
            wr_addr      <= '0;
            o_credit_ret <= 1'b0;
        end else begin
            o_credit_ret <= 1'b0;
            case (state)
                W_EMPTY: if (i_word_valid) state <= W_REQ;
                W_REQ: begin
                    // busy stays high until the sequencer grants the port
                    if (!req.busy) begin
                        state   <= W_WAIT;
                        wr_addr <= wr_addr + 1'b1;
                    end
                end
                W_WAIT: begin
                    if (!req.busy) begin
                        state        <= W_EMPTY;
                        o_credit_ret <= 1'b1;
                    end
                end
                default: state <= W_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == W_EMPTY && i_word_valid)
            hold_word <= i_word;
    end

endmodule

`default_nettype wire

//--- src/word_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word buffer
// circular FIFO with credit return upstream and credit spend downstream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module word_fifo #(
    parameter int FIFO_DEPTH = boot_cfg_pkg::FIFO_DEPTH
) (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_in_valid,
    input  logic [boot_cfg_pkg::DATA_W-1:0] i_in_word,
    output logic                            o_credit_ret,
    output logic                            o_out_valid,
    output logic [boot_cfg_pkg::DATA_W-1:0] o_out_word,
    input  logic                            i_out_credit
);
    import boot_cfg_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(FIFO_DEPTH - 1);

    logic [DATA_W-1:0]   mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CREDIT_W-1:0] fill;          // entries held
    logic [CREDIT_W-1:0] dn_credits;    // free slots at the writer
    logic                pop;

    // upstream credits guarantee a free slot for every incoming word
    assign pop = (fill != '0) && (dn_credits != '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fill         <= '0;
            dn_credits   <= CREDIT_W'(1);   // writer holds one word
            o_out_valid  <= 1'b0;
            o_credit_ret <= 1'b0;
        end else begin
            if (i_in_valid)
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            fill         <= fill + CREDIT_W'(i_in_valid) - CREDIT_W'(pop);
            dn_credits   <= dn_credits - CREDIT_W'(pop) + CREDIT_W'(i_out_credit);
            o_out_valid  <= pop;
            o_credit_ret <= pop;    // slot freed, hand credit back
        end
    end

    always_ff @(posedge clk) begin
        if (i_in_valid)
            mem[wr_ptr] <= i_in_word;
        if (pop)
            o_out_word <= mem[rd_ptr];
    end

endmodule

`default_nettype wire

//--- src/image_intake.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// image intake
// takes source words against buffer credits, counts them and sums them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module image_intake #(
    parameter int IMAGE_WORDS = boot_cfg_pkg::IMAGE_WORDS,
    parameter int FIFO_DEPTH  = boot_cfg_pkg::FIFO_DEPTH
) (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_src_valid,
    input  logic [boot_cfg_pkg::DATA_W-1:0] i_src_data,
    output logic                            o_src_ready,
    output logic                            o_word_valid,
    output logic [boot_cfg_pkg::DATA_W-1:0] o_word,
    input  logic                            i_credit_ret,
    output logic [boot_cfg_pkg::DATA_W-1:0] o_checksum,
    output logic                            o_load_complete
);
    import boot_cfg_pkg::*;

    localparam int CNT_W = $clog2(IMAGE_WORDS + 1);

    logic [CREDIT_W-1:0] credits;
    logic [CREDIT_W-1:0] credits_nxt;
    logic [CNT_W-1:0]    word_cnt;
    logic [CNT_W-1:0]    word_cnt_nxt;
    logic                take;

    assign take         = i_src_valid && o_src_ready;
    assign credits_nxt  = credits - CREDIT_W'(take) + CREDIT_W'(i_credit_ret);
    assign word_cnt_nxt = word_cnt + CNT_W'(take);

    assign o_load_complete = (word_cnt == CNT_W'(IMAGE_WORDS));

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            credits      <= CREDIT_W'(FIFO_DEPTH);
            word_cnt     <= '0;
            o_src_ready  <= 1'b0;
            o_word_valid <= 1'b0;
            o_checksum   <= '0;
        end else begin
            credits      <= credits_nxt;
            word_cnt     <= word_cnt_nxt;
            // ready only with a credit left and the image not yet complete
            o_src_ready  <= (credits_nxt != '0) && (word_cnt_nxt < CNT_W'(IMAGE_WORDS));
            o_word_valid <= take;
            if (take)
                o_checksum <= o_checksum + i_src_data;  // wraps at 2**DATA_W
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            o_word <= i_src_data;
    end

endmodule

`default_nettype wire

//--- src/mem_req_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory request interface
// one requester towards the port arbiter, busy/idle handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface mem_req_if;
    import boot_cfg_pkg::*;
    import boot_types_pkg::*;

    mem_op_t             op;        // held until an edge with busy low
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W-1:0]   rdata;
    logic                rvalid;    // one cycle per read
    logic                busy;

    modport master (
        output op, addr, wdata,
        input  rdata, rvalid, busy
    );

    modport slave (
        input  op, addr, wdata,
        output rdata, rvalid, busy
    );

endinterface

`default_nettype wire

//--- src/boot_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot types package
// boot phase encoding and memory request operation codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package boot_types_pkg;

    // boot phases, always stepped in this order
    typedef enum logic [1:0] {
        ZERO,       // clear the whole region
        LOAD,       // copy image from the stream
        VERIFY,     // read back and sum
        RUN         // host owns the port
    } boot_phase_t;

    // operation on a memory request port
    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE
    } mem_op_t;

endpackage

`default_nettype wire

//--- src/boot_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot configuration package
// word and address widths, boot region size, image length, buffer depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package boot_cfg_pkg;

    localparam int DATA_W = 32;         // one memory word
    localparam int ADDR_W = 12;         // word address, not byte address

    // boot region cleared by zero fill
    localparam int MEM_WORDS = 64;

    // image copied from the source stream, starting at word 0
    localparam int IMAGE_WORDS = 40;

    localparam int FIFO_DEPTH = 4;      // also the intake's starting credits
    localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

endpackage

`default_nettype wire
